//--- alu_dpath.f
+incdir+verif
hdl/alu_dpath_pkg.sv
hdl/alu_req_mux.sv
hdl/alu_shifter.sv
hdl/alu_addsub.sv
hdl/alu_result_sel.sv
hdl/alu_sbf.sv
hdl/alu_dpath.sv
verif/alu_dpath_tb.sv

//--- hdl/alu_addsub.sv
// Shared adder
// Serves add, sub and every less-than style compare
// Bit 32 of the result flags op1 below op2 after a subtract

module alu_addsub (
  input  alu_dpath_pkg::alu_op_e             mux_op,
  input  alu_dpath_pkg::alu_word_t           mux_op1,
  input  alu_dpath_pkg::alu_word_t           mux_op2,
  output logic [alu_dpath_pkg::adder_w-1:0] adder_res
);

  import alu_dpath_pkg::*;

  logic               op_unsigned;
  logic               adder_sub;
  logic               adder_en;
  logic [adder_w-1:0] ext_op1;
  logic [adder_w-1:0] ext_op2;
  logic [adder_w-1:0] adder_in1;
  logic [adder_w-1:0] adder_in2;

  // Unsigned operations extend with zero, all others with the sign
  assign op_unsigned = (mux_op == op_sltu) || (mux_op == op_cmp_ltu)
                    || (mux_op == op_cmp_gtu) || (mux_op == op_maxu)
                    || (mux_op == op_minu);

  // Everything that compares is a subtract
  assign adder_sub = (mux_op == op_sub)
                  || (mux_op == op_slt) || (mux_op == op_sltu)
                  || (mux_op == op_max) || (mux_op == op_min)
                  || (mux_op == op_maxu) || (mux_op == op_minu)
                  || (mux_op == op_cmp_lt) || (mux_op == op_cmp_gt)
                  || (mux_op == op_cmp_ltu) || (mux_op == op_cmp_gtu);
  assign adder_en  = adder_sub || (mux_op == op_add);

  assign ext_op1 = {{(adder_w-xlen){~op_unsigned & mux_op1[xlen-1]}}, mux_op1};
  assign ext_op2 = {{(adder_w-xlen){~op_unsigned & mux_op2[xlen-1]}}, mux_op2};

  ////////////////////////////////////////
  // Gated adder

  // Idle adder sees zeros
  assign adder_in1 = {adder_w{adder_en}} & ext_op1;
  // Subtract as op1 + ~op2 + 1
  assign adder_in2 = {adder_w{adder_en}} & (adder_sub ? ~ext_op2 : ext_op2);

  assign adder_res = adder_in1 + adder_in2 + adder_sub;

endmodule

//--- hdl/alu_dpath.sv
// Shared execution datapath of the core
// ALU, branch unit and AGU share one adder, shifter and logic unit
// Also holds the two AGU shared buffers

module alu_dpath (
  input  logic                     clk,
  input  logic                     rst_n,
  // Regular ALU
  input  logic                     alu_req_alu,
  input  logic                     alu_req_alu_add,
  input  logic                     alu_req_alu_sub,
  input  logic                     alu_req_alu_xor,
  input  logic                     alu_req_alu_sll,
  input  logic                     alu_req_alu_srl,
  input  logic                     alu_req_alu_sra,
  input  logic                     alu_req_alu_or,
  input  logic                     alu_req_alu_and,
  input  logic                     alu_req_alu_slt,
  input  logic                     alu_req_alu_sltu,
  input  logic                     alu_req_alu_lui,
  input  alu_dpath_pkg::alu_word_t alu_req_alu_op1,
  input  alu_dpath_pkg::alu_word_t alu_req_alu_op2,
  output alu_dpath_pkg::alu_word_t alu_req_alu_res,
  // Branch unit
  input  logic                     bjp_req_alu,
  input  logic                     bjp_req_alu_cmp_eq,
  input  logic                     bjp_req_alu_cmp_ne,
  input  logic                     bjp_req_alu_cmp_lt,
  input  logic                     bjp_req_alu_cmp_gt,
  input  logic                     bjp_req_alu_cmp_ltu,
  input  logic                     bjp_req_alu_cmp_gtu,
  input  logic                     bjp_req_alu_add,
  input  alu_dpath_pkg::alu_word_t bjp_req_alu_op1,
  input  alu_dpath_pkg::alu_word_t bjp_req_alu_op2,
  output logic                     bjp_req_alu_cmp_res,
  output alu_dpath_pkg::alu_word_t bjp_req_alu_add_res,
  // Address unit
  input  logic                     agu_req_alu,
  input  logic                     agu_req_alu_swap,
  input  logic                     agu_req_alu_add,
  input  logic                     agu_req_alu_and,
  input  logic                     agu_req_alu_or,
  input  logic                     agu_req_alu_xor,
  input  logic                     agu_req_alu_max,
  input  logic                     agu_req_alu_min,
  input  logic                     agu_req_alu_maxu,
  input  logic                     agu_req_alu_minu,
  input  alu_dpath_pkg::alu_word_t agu_req_alu_op1,
  input  alu_dpath_pkg::alu_word_t agu_req_alu_op2,
  output alu_dpath_pkg::alu_word_t agu_req_alu_res,
  // AGU shared buffers
  input  logic                     agu_sbf_0_ena,
  input  alu_dpath_pkg::alu_word_t agu_sbf_0_nxt,
  output alu_dpath_pkg::alu_word_t agu_sbf_0_r,
  input  logic                     agu_sbf_1_ena,
  input  alu_dpath_pkg::alu_word_t agu_sbf_1_nxt,
  output alu_dpath_pkg::alu_word_t agu_sbf_1_r
);

  import alu_dpath_pkg::*;

  alu_word_t          mux_op1;
  alu_word_t          mux_op2;
  alu_op_e            mux_op;
  alu_word_t          shift_res;
  logic [adder_w-1:0] adder_res;
  alu_word_t          dpath_res;
  logic               cmp_res;

  ////////////////////////////////////////
  // Shared units, names line up port to wire

  alu_req_mux    u_req_mux    (.*);
  alu_shifter    u_shifter    (.*);
  alu_addsub     u_addsub     (.*);
  alu_result_sel u_result_sel (.*);
  alu_sbf        u_sbf        (.*);

  // One result fans out to every requestor
  assign alu_req_alu_res     = dpath_res;
  assign agu_req_alu_res     = dpath_res;
  assign bjp_req_alu_add_res = dpath_res;
  assign bjp_req_alu_cmp_res = cmp_res;

endmodule

//--- hdl/alu_dpath_pkg.sv
// Shared definitions for the execution datapath
// Widths, the word type and the datapath opcode

package alu_dpath_pkg;

  ////////////////////////////////////////
  // Widths

  // Datapath width of the core
  localparam int xlen    = 32;
  // Shift amount taken from the low bits of op2
  localparam int shamt_w = 5;
  // One extra bit holds the sign of a difference
  localparam int adder_w = xlen + 1;

  // Operand, result and buffer word
  typedef logic [xlen-1:0] alu_word_t;

  ////////////////////////////////////////
  // Datapath opcode

  // One value per operation the shared units can perform
  typedef enum logic [4:0] {
    op_none,
    op_add,
    op_sub,
    op_xor,
    op_or,
    op_and,
    op_sll,
    op_srl,
    op_sra,
    op_slt,
    op_sltu,
    // Move of op2, used by lui and swap
    op_mvop2,
    op_max,
    op_min,
    op_maxu,
    op_minu,
    op_cmp_eq,
    op_cmp_ne,
    op_cmp_lt,
    op_cmp_gt,
    op_cmp_ltu,
    op_cmp_gtu
  } alu_op_e;

endpackage

//--- hdl/alu_req_mux.sv
// Requestor mux for the shared datapath
// Picks the active requestor's operands and turns its strobes into one opcode

module alu_req_mux (
  input  logic                    alu_req_alu,
  input  logic                    alu_req_alu_add,
  input  logic                    alu_req_alu_sub,
  input  logic                    alu_req_alu_xor,
  input  logic                    alu_req_alu_sll,
  input  logic                    alu_req_alu_srl,
  input  logic                    alu_req_alu_sra,
  input  logic                    alu_req_alu_or,
  input  logic                    alu_req_alu_and,
  input  logic                    alu_req_alu_slt,
  input  logic                    alu_req_alu_sltu,
  input  logic                    alu_req_alu_lui,
  input  alu_dpath_pkg::alu_word_t alu_req_alu_op1,
  input  alu_dpath_pkg::alu_word_t alu_req_alu_op2,
  input  logic                    bjp_req_alu,
  input  logic                    bjp_req_alu_cmp_eq,
  input  logic                    bjp_req_alu_cmp_ne,
  input  logic                    bjp_req_alu_cmp_lt,
  input  logic                    bjp_req_alu_cmp_gt,
  input  logic                    bjp_req_alu_cmp_ltu,
  input  logic                    bjp_req_alu_cmp_gtu,
  input  logic                    bjp_req_alu_add,
  input  alu_dpath_pkg::alu_word_t bjp_req_alu_op1,
  input  alu_dpath_pkg::alu_word_t bjp_req_alu_op2,
  input  logic                    agu_req_alu,
  input  logic                    agu_req_alu_swap,
  input  logic                    agu_req_alu_add,
  input  logic                    agu_req_alu_and,
  input  logic                    agu_req_alu_or,
  input  logic                    agu_req_alu_xor,
  input  logic                    agu_req_alu_max,
  input  logic                    agu_req_alu_min,
  input  logic                    agu_req_alu_maxu,
  input  logic                    agu_req_alu_minu,
  input  alu_dpath_pkg::alu_word_t agu_req_alu_op1,
  input  alu_dpath_pkg::alu_word_t agu_req_alu_op2,
  output alu_dpath_pkg::alu_word_t mux_op1,
  output alu_dpath_pkg::alu_word_t mux_op2,
  output alu_dpath_pkg::alu_op_e  mux_op
);

  import alu_dpath_pkg::*;

  logic [2:0]  req_vec;
  logic [10:0] alu_ops;
  logic [6:0]  bjp_ops;
  logic [8:0]  agu_ops;
  alu_op_e     alu_enc;
  alu_op_e     bjp_enc;
  alu_op_e     agu_enc;

  assign req_vec = {alu_req_alu, bjp_req_alu, agu_req_alu};
  // Operation strobes per requestor, in the same order as the encoders below
  assign alu_ops = {alu_req_alu_add, alu_req_alu_sub, alu_req_alu_xor, alu_req_alu_sll,
                    alu_req_alu_srl, alu_req_alu_sra, alu_req_alu_or, alu_req_alu_and,
                    alu_req_alu_slt, alu_req_alu_sltu, alu_req_alu_lui};
  assign bjp_ops = {bjp_req_alu_cmp_eq, bjp_req_alu_cmp_ne, bjp_req_alu_cmp_lt,
                    bjp_req_alu_cmp_gt, bjp_req_alu_cmp_ltu, bjp_req_alu_cmp_gtu,
                    bjp_req_alu_add};
  assign agu_ops = {agu_req_alu_swap, agu_req_alu_add, agu_req_alu_and, agu_req_alu_or,
                    agu_req_alu_xor, agu_req_alu_max, agu_req_alu_min, agu_req_alu_maxu,
                    agu_req_alu_minu};

  ////////////////////////////////////////
  // Operand select

  // AND-OR mux, all zero when idle
  assign mux_op1 = ({xlen{alu_req_alu}} & alu_req_alu_op1)
                 | ({xlen{bjp_req_alu}} & bjp_req_alu_op1)
                 | ({xlen{agu_req_alu}} & agu_req_alu_op1);
  assign mux_op2 = ({xlen{alu_req_alu}} & alu_req_alu_op2)
                 | ({xlen{bjp_req_alu}} & bjp_req_alu_op2)
                 | ({xlen{agu_req_alu}} & agu_req_alu_op2);

  ////////////////////////////////////////
  // Opcode encode

  always_comb begin
    alu_enc = op_none;
    bjp_enc = op_none;
    agu_enc = op_none;
    // Regular ALU, lui is a plain move of op2
    if (alu_req_alu_add)  alu_enc = op_add;
    if (alu_req_alu_sub)  alu_enc = op_sub;
    if (alu_req_alu_xor)  alu_enc = op_xor;
    if (alu_req_alu_sll)  alu_enc = op_sll;
    if (alu_req_alu_srl)  alu_enc = op_srl;
    if (alu_req_alu_sra)  alu_enc = op_sra;
    if (alu_req_alu_or)   alu_enc = op_or;
    if (alu_req_alu_and)  alu_enc = op_and;
    if (alu_req_alu_slt)  alu_enc = op_slt;
    if (alu_req_alu_sltu) alu_enc = op_sltu;
    if (alu_req_alu_lui)  alu_enc = op_mvop2;
    // Branch unit compares and target add
    if (bjp_req_alu_cmp_eq)  bjp_enc = op_cmp_eq;
    if (bjp_req_alu_cmp_ne)  bjp_enc = op_cmp_ne;
    if (bjp_req_alu_cmp_lt)  bjp_enc = op_cmp_lt;
    if (bjp_req_alu_cmp_gt)  bjp_enc = op_cmp_gt;
    if (bjp_req_alu_cmp_ltu) bjp_enc = op_cmp_ltu;
    if (bjp_req_alu_cmp_gtu) bjp_enc = op_cmp_gtu;
    if (bjp_req_alu_add)     bjp_enc = op_add;
    // Address unit, swap moves op2 like lui
    if (agu_req_alu_swap) agu_enc = op_mvop2;
    if (agu_req_alu_add)  agu_enc = op_add;
    if (agu_req_alu_and)  agu_enc = op_and;
    if (agu_req_alu_or)   agu_enc = op_or;
    if (agu_req_alu_xor)  agu_enc = op_xor;
    if (agu_req_alu_max)  agu_enc = op_max;
    if (agu_req_alu_min)  agu_enc = op_min;
    if (agu_req_alu_maxu) agu_enc = op_maxu;
    if (agu_req_alu_minu) agu_enc = op_minu;
  end

  // Only one requestor is ever active
  assign mux_op = alu_req_alu ? alu_enc :
                  bjp_req_alu ? bjp_enc :
                  agu_req_alu ? agu_enc : op_none;

  // The three requestor units arbitrate upstream, so never two at once
  always_comb begin
    a_one_requestor: assert final ($isunknown(req_vec) || $onehot0(req_vec));
    // The decoders upstream raise at most one strobe per request
    a_one_op: assert final ($isunknown(req_vec)
                            || ((!alu_req_alu || $onehot0(alu_ops))
                             && (!bjp_req_alu || $onehot0(bjp_ops))
                             && (!agu_req_alu || $onehot0(agu_ops))));
  end

endmodule

//--- hdl/alu_result_sel.sv
// Result select for the shared datapath
// Holds the logic unit and derives compare, slt, max/min and move results,
// then picks the final result by a one-hot AND-OR

module alu_result_sel (
  input  alu_dpath_pkg::alu_op_e             mux_op,
  input  alu_dpath_pkg::alu_word_t           mux_op1,
  input  alu_dpath_pkg::alu_word_t           mux_op2,
  input  alu_dpath_pkg::alu_word_t           shift_res,
  input  logic [alu_dpath_pkg::adder_w-1:0] adder_res,
  output alu_dpath_pkg::alu_word_t           dpath_res,
  output logic                              cmp_res
);

  import alu_dpath_pkg::*;

  logic      xorer_en;
  logic      neq;
  logic      op1_lt_op2;
  logic      sel_addsub;
  logic      sel_shift;
  logic      sel_slttu;
  logic      sel_maxmin;
  logic      maxmin_op1;
  alu_word_t xorer_res;
  alu_word_t orer_res;
  alu_word_t ander_res;
  alu_word_t slttu_res;
  alu_word_t maxmin_res;

  ////////////////////////////////////////
  // Logic unit

  // The xor-er also checks eq and ne, so it is gated
  assign xorer_en  = (mux_op == op_xor) || (mux_op == op_cmp_eq) || (mux_op == op_cmp_ne);
  assign xorer_res = ({xlen{xorer_en}} & mux_op1) ^ ({xlen{xorer_en}} & mux_op2);
  // Too small to be worth gating
  assign orer_res  = mux_op1 | mux_op2;
  assign ander_res = mux_op1 & mux_op2;

  ////////////////////////////////////////
  // Compare

  assign neq        = |xorer_res;
  // Borrow out of the 33-bit subtract
  assign op1_lt_op2 = adder_res[xlen];

  // Greater is taken as not less
  always_comb begin
    case (mux_op)
      op_cmp_eq:  cmp_res = ~neq;
      op_cmp_ne:  cmp_res = neq;
      op_cmp_lt,
      op_cmp_ltu: cmp_res = op1_lt_op2;
      op_cmp_gt,
      op_cmp_gtu: cmp_res = ~op1_lt_op2;
      default:    cmp_res = 1'b0;
    endcase
  end

  // slt and sltu give 0 or 1
  assign slttu_res = {{(xlen-1){1'b0}}, op1_lt_op2};

  // On equal operands max keeps op1 and min keeps op2
  assign maxmin_op1 = (((mux_op == op_max) || (mux_op == op_maxu)) && !op1_lt_op2)
                   || (((mux_op == op_min) || (mux_op == op_minu)) && op1_lt_op2);
  assign maxmin_res = maxmin_op1 ? mux_op1 : mux_op2;

  ////////////////////////////////////////
  // Final select

  assign sel_addsub = (mux_op == op_add) || (mux_op == op_sub);
  // Shifter output is already zero for other opcodes
  assign sel_shift  = (mux_op == op_sll) || (mux_op == op_srl) || (mux_op == op_sra);
  assign sel_slttu  = (mux_op == op_slt) || (mux_op == op_sltu);
  assign sel_maxmin = (mux_op == op_max) || (mux_op == op_min)
                   || (mux_op == op_maxu) || (mux_op == op_minu);

  assign dpath_res = ({xlen{mux_op == op_or}}    & orer_res)
                   | ({xlen{mux_op == op_and}}   & ander_res)
                   | ({xlen{mux_op == op_xor}}   & xorer_res)
                   | ({xlen{sel_addsub}}         & adder_res[xlen-1:0])
                   | ({xlen{sel_shift}}          & shift_res)
                   | ({xlen{mux_op == op_mvop2}} & mux_op2)
                   | ({xlen{sel_slttu}}          & slttu_res)
                   | ({xlen{sel_maxmin}}         & maxmin_res);

endmodule

//--- hdl/alu_sbf.sv
// Shared buffers for the AGU
// Two independent registers loaded on their own enables

module alu_sbf (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     agu_sbf_0_ena,
  input  logic                     agu_sbf_1_ena,
  input  alu_dpath_pkg::alu_word_t agu_sbf_0_nxt,
  input  alu_dpath_pkg::alu_word_t agu_sbf_1_nxt,
  output alu_dpath_pkg::alu_word_t agu_sbf_0_r,
  output alu_dpath_pkg::alu_word_t agu_sbf_1_r
);

  import alu_dpath_pkg::*;

  // Buffer 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      agu_sbf_0_r <= '0;
    end else if (agu_sbf_0_ena) begin
      agu_sbf_0_r <= agu_sbf_0_nxt;
    end
  end

  // Buffer 1
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      agu_sbf_1_r <= '0;
    end else if (agu_sbf_1_ena) begin
      agu_sbf_1_r <= agu_sbf_1_nxt;
    end
  end

  // AGU must drive both enables once out of reset
  a_ena_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({agu_sbf_0_ena, agu_sbf_1_ena}));

endmodule

//--- hdl/alu_shifter.sv
// Shared shifter
// One left shifter does sll, and srl/sra through bit reversal

module alu_shifter (
  input  alu_dpath_pkg::alu_op_e   mux_op,
  input  alu_dpath_pkg::alu_word_t mux_op1,
  input  alu_dpath_pkg::alu_word_t mux_op2,
  output alu_dpath_pkg::alu_word_t shift_res
);

  import alu_dpath_pkg::*;

  logic               op_shift;
  logic               op_right;
  logic [shamt_w-1:0] sh_amt;
  alu_word_t          op1_rev;
  alu_word_t          sh_in;
  alu_word_t          sh_out;
  alu_word_t          srl_res;
  alu_word_t          fill_mask;

  assign op_shift = (mux_op == op_sll) || (mux_op == op_srl) || (mux_op == op_sra);
  assign op_right = (mux_op == op_srl) || (mux_op == op_sra);

  // Inputs held at zero outside shifts so the shifter does not toggle
  assign sh_amt  = {shamt_w{op_shift}} & mux_op2[shamt_w-1:0];
  // Right shifts become left shifts on the reversed word
  assign op1_rev = {<<{mux_op1}};
  assign sh_in   = {xlen{op_shift}} & (op_right ? op1_rev : mux_op1);

  assign sh_out  = sh_in << sh_amt;
  assign srl_res = {<<{sh_out}};

  // Ones where the shifted data lands and zeros in the vacated high bits
  assign fill_mask = {xlen{1'b1}} >> sh_amt;

  always_comb begin
    case (mux_op)
      op_sll:  shift_res = sh_out;
      op_srl:  shift_res = srl_res;
      // Sign of op1 fills the vacated bits
      op_sra:  shift_res = (srl_res & fill_mask) | ({xlen{mux_op1[xlen-1]}} & ~fill_mask);
      default: shift_res = '0;
    endcase
  end

endmodule

//--- verif/alu_dpath_model.svh
// Reference model for the shared execution datapath
// Expected results, compares and buffer updates from the datapath rules

`ifndef ALU_DPATH_MODEL_SVH
`define ALU_DPATH_MODEL_SVH

// ALU strobe index: add, sub, xor, sll, srl, sra, or, and, slt, sltu, lui
// Index 11 is a request with no operation strobe
function automatic alu_word_t alu_result(int op, alu_word_t a, alu_word_t b);
  int sh;
  // Shift amount is op2 bits 4..0 only
  sh = b[4:0];
  case (op)
    0:  return a + b;
    // Wraps modulo 2^32
    1:  return a - b;
    2:  return a ^ b;
    3:  return a << sh;
    4:  return a >> sh;
    // Fill with op1 bit 31
    5:  return $signed(a) >>> sh;
    6:  return a | b;
    7:  return a & b;
    8:  return ($signed(a) < $signed(b)) ? 1 : 0;
    9:  return (a < b) ? 1 : 0;
    // lui moves op2
    10: return b;
    default: return '0;
  endcase
endfunction

// BJP strobe index: eq, ne, lt, gt, ltu, gtu, add
// Greater means not less, so equal operands give gt true
function automatic logic bjp_compare(int op, alu_word_t a, alu_word_t b);
  case (op)
    0: return a == b;
    1: return a != b;
    2: return $signed(a) < $signed(b);
    3: return !($signed(a) < $signed(b));
    4: return a < b;
    5: return !(a < b);
    // Target add and empty requests never flag a compare
    default: return 1'b0;
  endcase
endfunction

// AGU strobe index: swap, add, and, or, xor, max, min, maxu, minu
function automatic alu_word_t agu_result(int op, alu_word_t a, alu_word_t b);
  case (op)
    0: return b;
    1: return a + b;
    2: return a & b;
    3: return a | b;
    4: return a ^ b;
    // On a tie max keeps op1, min keeps op2
    5: return ($signed(a) >= $signed(b)) ? a : b;
    6: return ($signed(a) < $signed(b)) ? a : b;
    7: return (a >= b) ? a : b;
    8: return (a < b) ? a : b;
    default: return '0;
  endcase
endfunction

// Buffer value after one clock edge
function automatic alu_word_t buffer_next(logic ena, alu_word_t cur, alu_word_t nxt);
  return ena ? nxt : cur;
endfunction

`endif

//--- verif/alu_dpath_tb.sv
// Testbench for the shared execution datapath
// Random requests from a fixed seed, checked against a reference model

module alu_dpath_tb;

  import alu_dpath_pkg::*;

  `include "alu_dpath_model.svh"

  logic      clk;
  logic      rst_n;
  // Regular ALU
  logic      alu_req_alu;
  logic      alu_req_alu_add, alu_req_alu_sub, alu_req_alu_xor, alu_req_alu_sll;
  logic      alu_req_alu_srl, alu_req_alu_sra, alu_req_alu_or, alu_req_alu_and;
  logic      alu_req_alu_slt, alu_req_alu_sltu, alu_req_alu_lui;
  alu_word_t alu_req_alu_op1, alu_req_alu_op2, alu_req_alu_res;
  // Branch unit
  logic      bjp_req_alu, bjp_req_alu_cmp_res;
  logic      bjp_req_alu_cmp_eq, bjp_req_alu_cmp_ne, bjp_req_alu_cmp_lt;
  logic      bjp_req_alu_cmp_gt, bjp_req_alu_cmp_ltu, bjp_req_alu_cmp_gtu, bjp_req_alu_add;
  alu_word_t bjp_req_alu_op1, bjp_req_alu_op2, bjp_req_alu_add_res;
  // Address unit
  logic      agu_req_alu;
  logic      agu_req_alu_swap, agu_req_alu_add, agu_req_alu_and, agu_req_alu_or;
  logic      agu_req_alu_xor, agu_req_alu_max, agu_req_alu_min, agu_req_alu_maxu;
  logic      agu_req_alu_minu;
  alu_word_t agu_req_alu_op1, agu_req_alu_op2, agu_req_alu_res;
  // Shared buffers
  logic      agu_sbf_0_ena, agu_sbf_1_ena;
  alu_word_t agu_sbf_0_nxt, agu_sbf_1_nxt, agu_sbf_0_r, agu_sbf_1_r;

  // Strobe vectors, bit n is operation index n of the model
  logic [10:0] alu_ops;
  logic [6:0]  bjp_ops;
  logic [8:0]  agu_ops;

  integer    seed;
  int        errors;
  int        checks;
  int        cur_req;
  int        cur_op;
  int        wait_cnt;
  logic      timed_out;
  alu_word_t cur_a;
  alu_word_t cur_b;
  alu_word_t exp_sbf0;
  alu_word_t exp_sbf1;

  assign {alu_req_alu_lui, alu_req_alu_sltu, alu_req_alu_slt, alu_req_alu_and, alu_req_alu_or,
          alu_req_alu_sra, alu_req_alu_srl, alu_req_alu_sll, alu_req_alu_xor, alu_req_alu_sub,
          alu_req_alu_add} = alu_ops;
  assign {bjp_req_alu_add, bjp_req_alu_cmp_gtu, bjp_req_alu_cmp_ltu, bjp_req_alu_cmp_gt,
          bjp_req_alu_cmp_lt, bjp_req_alu_cmp_ne, bjp_req_alu_cmp_eq} = bjp_ops;
  assign {agu_req_alu_minu, agu_req_alu_maxu, agu_req_alu_min, agu_req_alu_max, agu_req_alu_xor,
          agu_req_alu_or, agu_req_alu_and, agu_req_alu_add, agu_req_alu_swap} = agu_ops;

  alu_dpath UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Stimulus and checks

  function automatic alu_word_t rand_operand();
    int kind;
    kind = $unsigned($random(seed)) % 8;
    // Corner values show up often enough to hit sign and wrap cases
    case (kind)
      0: return '0;
      1: return '1;
      2: return 32'h8000_0000;
      3: return 32'h7fff_ffff;
      default: return $random(seed);
    endcase
  endfunction

  task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s expected %h got %h", name, expected, actual);
    end
  endtask

  task automatic drive_request();
    int        n_ops;
    alu_word_t a;
    alu_word_t b;
    alu_ops     = '0;
    bjp_ops     = '0;
    agu_ops     = '0;
    alu_req_alu = 1'b0;
    bjp_req_alu = 1'b0;
    agu_req_alu = 1'b0;
    // Idle requestors carry junk operands, which must not leak through
    alu_req_alu_op1 = $random(seed);
    alu_req_alu_op2 = $random(seed);
    bjp_req_alu_op1 = $random(seed);
    bjp_req_alu_op2 = $random(seed);
    agu_req_alu_op1 = $random(seed);
    agu_req_alu_op2 = $random(seed);
    a = rand_operand();
    b = rand_operand();
    if ($unsigned($random(seed)) % 8 == 0) b = a;
    cur_req = $unsigned($random(seed)) % 4;
    n_ops   = (cur_req == 1) ? 11 : (cur_req == 2) ? 7 : 9;
    // One past the last index leaves the request with no operation strobe
    cur_op  = $unsigned($random(seed)) % (n_ops + 1);
    case (cur_req)
      1: begin
        alu_req_alu     = 1'b1;
        alu_ops         = 11'b1 << cur_op;
        alu_req_alu_op1 = a;
        alu_req_alu_op2 = b;
      end
      2: begin
        bjp_req_alu     = 1'b1;
        bjp_ops         = 7'b1 << cur_op;
        bjp_req_alu_op1 = a;
        bjp_req_alu_op2 = b;
      end
      3: begin
        agu_req_alu     = 1'b1;
        agu_ops         = 9'b1 << cur_op;
        agu_req_alu_op1 = a;
        agu_req_alu_op2 = b;
      end
      default: ;
    endcase
    cur_a = a;
    cur_b = b;
    // Sparse loads so that held buffer values get exercised
    agu_sbf_0_ena = ($unsigned($random(seed)) % 4 == 0);
    agu_sbf_1_ena = ($unsigned($random(seed)) % 4 == 0);
    agu_sbf_0_nxt = $random(seed);
    agu_sbf_1_nxt = $random(seed);
  endtask

  task automatic check_outputs();
    case (cur_req)
      1: begin
        compare_value("alu_req_alu_res", alu_result(cur_op, cur_a, cur_b), alu_req_alu_res);
        compare_value("bjp_req_alu_cmp_res", 0, bjp_req_alu_cmp_res);
      end
      2: begin
        compare_value("bjp_req_alu_cmp_res", bjp_compare(cur_op, cur_a, cur_b),
                      bjp_req_alu_cmp_res);
        // Target add
        if (cur_op == 6) compare_value("bjp_req_alu_add_res", cur_a + cur_b, bjp_req_alu_add_res);
      end
      3: begin
        compare_value("agu_req_alu_res", agu_result(cur_op, cur_a, cur_b), agu_req_alu_res);
        compare_value("bjp_req_alu_cmp_res", 0, bjp_req_alu_cmp_res);
      end
      default: begin
        // Idle cycle, everything quiet
        compare_value("alu_req_alu_res", 0, alu_req_alu_res);
        compare_value("agu_req_alu_res", 0, agu_req_alu_res);
        compare_value("bjp_req_alu_add_res", 0, bjp_req_alu_add_res);
        compare_value("bjp_req_alu_cmp_res", 0, bjp_req_alu_cmp_res);
      end
    endcase
    compare_value("agu_sbf_0_r", exp_sbf0, agu_sbf_0_r);
    compare_value("agu_sbf_1_r", exp_sbf1, agu_sbf_1_r);
  endtask

  ////////////////////////////////////////
  // Main sequence

  initial begin
    seed          = 32'hfc05;
    errors        = 0;
    checks        = 0;
    timed_out     = 1'b0;
    exp_sbf0      = '0;
    exp_sbf1      = '0;
    rst_n         = 1'b0;
    alu_ops       = '0;
    bjp_ops       = '0;
    agu_ops       = '0;
    alu_req_alu   = 1'b0;
    bjp_req_alu   = 1'b0;
    agu_req_alu   = 1'b0;
    alu_req_alu_op1 = '0;
    alu_req_alu_op2 = '0;
    bjp_req_alu_op1 = '0;
    bjp_req_alu_op2 = '0;
    agu_req_alu_op1 = '0;
    agu_req_alu_op2 = '0;
    agu_sbf_0_ena = 1'b0;
    agu_sbf_1_ena = 1'b0;
    agu_sbf_0_nxt = '0;
    agu_sbf_1_nxt = '0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    // Buffers should already read zero, allow a few cycles at most
    wait_cnt = 0;
    while ((agu_sbf_0_r !== '0 || agu_sbf_1_r !== '0) && wait_cnt < 4) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (wait_cnt >= 4) begin
      $display("Timeout: shared buffers did not read zero after reset release");
      errors++;
      timed_out = 1'b1;
    end
    compare_value("agu_sbf_0_r", 0, agu_sbf_0_r);
    compare_value("agu_sbf_1_r", 0, agu_sbf_1_r);
    if (!timed_out) begin
      for (int i = 0; i < 3000; i++) begin
        @(posedge clk);
        #1;
        // Model takes the loads sampled on the edge just passed
        exp_sbf0 = buffer_next(agu_sbf_0_ena, exp_sbf0, agu_sbf_0_nxt);
        exp_sbf1 = buffer_next(agu_sbf_1_ena, exp_sbf1, agu_sbf_1_nxt);
        drive_request();
        // Results are combinational, sample just before the next edge
        #8;
        check_outputs();
      end
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
